// ==== verilog/scene_pkg.sv ====
package scene_pkg;

  // ==============================
  // Sizes and timing
  // ==============================

  // Clock cycles per serial bit
  localparam int CLKS_PER_BIT = 8;

  localparam int FP_WIDTH          = 16;
  localparam int OBJ_IDX_WIDTH     = 4;
  localparam int MAX_BOUNCES_WIDTH = 8;
  localparam int NUM_OBJS          = 16;

  // Payload register size and per-command payload lengths, in bytes
  localparam int MAX_DATA_BYTES    = 16;
  localparam int CAM_BYTES         = 6;
  localparam int OBJ_IDX_BYTES     = 1;
  localparam int OBJ_BYTES         = 11;
  localparam int NUM_OBJS_BYTES    = 1;
  localparam int MAX_BOUNCES_BYTES = 1;

  // ==============================
  // Types
  // ==============================

  typedef logic [7:0]                    byte_t;
  typedef logic [FP_WIDTH-1:0]           fp_t;
  typedef logic [OBJ_IDX_WIDTH-1:0]      obj_idx_t;
  typedef logic [MAX_BOUNCES_WIDTH-1:0]  bounces_t;
  typedef logic [MAX_DATA_BYTES*8-1:0]   flash_data_t;
  typedef logic [23:0]                   color_t;

  // Command byte codes sent by the host
  typedef enum logic [7:0] {
    CMD_CAM_POS     = 8'h00,
    CMD_CAM_DIR     = 8'h01,
    CMD_CAM_RIGHT   = 8'h02,
    CMD_CAM_UP      = 8'h03,
    CMD_OBJ_IDX     = 8'h04,
    CMD_OBJ_DATA    = 8'h05,
    CMD_NUM_OBJS    = 8'h06,
    CMD_MAX_BOUNCES = 8'h07
  } flash_cmd_t;

  // First field is the most significant, matching MSB-first payloads
  typedef struct packed {
    fp_t x;
    fp_t y;
    fp_t z;
  } fp_vec3_t;

  typedef struct packed {
    fp_vec3_t center;
    fp_t      radius;
    color_t   color;
  } object_t;

  typedef struct packed {
    fp_vec3_t pos;
    fp_vec3_t dir;
    fp_vec3_t right;
    fp_vec3_t up;
  } camera_t;

  // Completed command from the collector, payload right-aligned
  typedef struct packed {
    flash_cmd_t  cmd;
    flash_data_t data;
  } flash_wr_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic              clk,
  input  logic              rst,
  input  logic              rx,
  output logic              rx_valid,
  output scene_pkg::byte_t  rx_byte
);

  typedef logic [$clog2(scene_pkg::CLKS_PER_BIT)-1:0] clk_cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_t;

  rx_state_t  state;
  clk_cnt_t   clk_cnt;
  logic [2:0] bit_cnt;

  logic rx_meta;
  logic rx_sync;

  // ==============================
  // Input synchronizer
  // ==============================

  // Line idles high, so reset to the idle level
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // ==============================
  // Frame FSM
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          // Falling edge marks the start bit
          if (!rx_sync) begin
            state <= START;
          end
        end
        START: begin
          // Check the start bit at its midpoint
          if (clk_cnt == clk_cnt_t'(scene_pkg::CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            if (rx_sync) begin
              // Glitch, not a real start bit
              state <= IDLE;
            end else begin
              state <= DATA;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        DATA: begin
          if (clk_cnt == clk_cnt_t'(scene_pkg::CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            // LSB first
            rx_byte <= {rx_sync, rx_byte[7:1]};
            if (bit_cnt == 3'd7) begin
              state <= STOP;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        STOP: begin
          if (clk_cnt == clk_cnt_t'(scene_pkg::CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            // Low stop bit drops the byte
            rx_valid <= rx_sync;
            state    <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/uart_memflash_rtx.sv ====
`timescale 1ns/1ps

module uart_memflash_rtx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_valid,
  input  scene_pkg::byte_t      rx_byte,
  output logic                  flash_active,
  output scene_pkg::flash_wr_t  flash_wr,
  output logic                  flash_wen
);

  typedef logic [$clog2(scene_pkg::MAX_DATA_BYTES)-1:0] byte_idx_t;

  typedef enum logic {
    IDLE,
    DATA
  } flash_state_t;

  flash_state_t state;
  byte_idx_t    byte_idx;
  byte_idx_t    last_byte_idx;

  logic      cmd_known;
  byte_idx_t cmd_last_idx;

  // ==============================
  // Command decode
  // ==============================

  // Index of the final payload byte for each command
  always_comb begin
    cmd_known    = 1'b1;
    cmd_last_idx = '0;
    case (rx_byte)
      scene_pkg::CMD_CAM_POS,
      scene_pkg::CMD_CAM_DIR,
      scene_pkg::CMD_CAM_RIGHT,
      scene_pkg::CMD_CAM_UP:
        cmd_last_idx = byte_idx_t'(scene_pkg::CAM_BYTES - 1);
      scene_pkg::CMD_OBJ_IDX:
        cmd_last_idx = byte_idx_t'(scene_pkg::OBJ_IDX_BYTES - 1);
      scene_pkg::CMD_OBJ_DATA:
        cmd_last_idx = byte_idx_t'(scene_pkg::OBJ_BYTES - 1);
      scene_pkg::CMD_NUM_OBJS:
        cmd_last_idx = byte_idx_t'(scene_pkg::NUM_OBJS_BYTES - 1);
      scene_pkg::CMD_MAX_BOUNCES:
        cmd_last_idx = byte_idx_t'(scene_pkg::MAX_BOUNCES_BYTES - 1);
      // Codes above 7 leave the parser idle
      default: cmd_known = 1'b0;
    endcase
  end

  // ==============================
  // Collector FSM
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      byte_idx     <= '0;
      flash_active <= 1'b0;
      flash_wen    <= 1'b0;
    end else begin
      flash_wen <= 1'b0;
      case (state)
        IDLE: begin
          if (rx_valid && cmd_known) begin
            flash_active <= 1'b1;
            state        <= DATA;
          end else begin
            flash_active <= 1'b0;
          end
        end
        DATA: begin
          if (rx_valid) begin
            if (byte_idx == last_byte_idx) begin
              byte_idx  <= '0;
              flash_wen <= 1'b1;
              state     <= IDLE;
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload path, held until the next command completes
  always_ff @(posedge clk) begin
    if (state == IDLE && rx_valid && cmd_known) begin
      flash_wr.cmd  <= scene_pkg::flash_cmd_t'(rx_byte);
      last_byte_idx <= cmd_last_idx;
    end
    if (state == DATA && rx_valid) begin
      // Bytes arrive MSB first and shift in at the bottom
      flash_wr.data <= {flash_wr.data[scene_pkg::MAX_DATA_BYTES*8-9:0], rx_byte};
    end
  end

endmodule

// ==== verilog/scene_regs.sv ====
`timescale 1ns/1ps

module scene_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flash_wen,
  input  scene_pkg::flash_wr_t  flash_wr,
  input  scene_pkg::obj_idx_t   obj_rd_idx,
  output scene_pkg::object_t    obj_rd_data,
  output scene_pkg::camera_t    camera,
  output scene_pkg::obj_idx_t   num_objs,
  output scene_pkg::bounces_t   max_bounces
);

  scene_pkg::object_t  obj_mem [scene_pkg::NUM_OBJS];
  scene_pkg::obj_idx_t obj_ptr;

  scene_pkg::fp_vec3_t wr_vec;
  scene_pkg::object_t  wr_obj;
  scene_pkg::obj_idx_t wr_idx;
  scene_pkg::bounces_t wr_bounces;

  // Views of the right-aligned payload
  assign wr_vec     = scene_pkg::fp_vec3_t'(flash_wr.data[$bits(scene_pkg::fp_vec3_t)-1:0]);
  assign wr_obj     = scene_pkg::object_t'(flash_wr.data[$bits(scene_pkg::object_t)-1:0]);
  assign wr_idx     = flash_wr.data[scene_pkg::OBJ_IDX_WIDTH-1:0];
  assign wr_bounces = flash_wr.data[scene_pkg::MAX_BOUNCES_WIDTH-1:0];

  // ==============================
  // Scene registers
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      camera      <= '0;
      obj_ptr     <= '0;
      num_objs    <= '0;
      max_bounces <= '0;
    end else if (flash_wen) begin
      case (flash_wr.cmd)
        scene_pkg::CMD_CAM_POS: begin
          camera.pos <= wr_vec;
        end
        scene_pkg::CMD_CAM_DIR: begin
          camera.dir <= wr_vec;
        end
        scene_pkg::CMD_CAM_RIGHT: begin
          camera.right <= wr_vec;
        end
        scene_pkg::CMD_CAM_UP: begin
          camera.up <= wr_vec;
        end
        scene_pkg::CMD_OBJ_IDX: begin
          obj_ptr <= wr_idx;
        end
        scene_pkg::CMD_OBJ_DATA: begin
          // Pointer wraps past the last object
          obj_ptr <= obj_ptr + 1'b1;
        end
        scene_pkg::CMD_NUM_OBJS: begin
          num_objs <= wr_idx;
        end
        scene_pkg::CMD_MAX_BOUNCES: begin
          max_bounces <= wr_bounces;
        end
        default: begin
        end
      endcase
    end
  end

  // ==============================
  // Object memory
  // ==============================

  always_ff @(posedge clk) begin
    if (flash_wen && flash_wr.cmd == scene_pkg::CMD_OBJ_DATA) begin
      obj_mem[obj_ptr] <= wr_obj;
    end
  end

  // Registered read for the renderer
  always_ff @(posedge clk) begin
    obj_rd_data <= obj_mem[obj_rd_idx];
  end

endmodule

// ==== verilog/scene_loader.sv ====
`timescale 1ns/1ps

module scene_loader (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx,
  input  scene_pkg::obj_idx_t  obj_rd_idx,
  output scene_pkg::object_t   obj_rd_data,
  output scene_pkg::camera_t   camera,
  output scene_pkg::obj_idx_t  num_objs,
  output scene_pkg::bounces_t  max_bounces,
  output logic                 loader_busy
);

  logic                 rx_valid;
  scene_pkg::byte_t     rx_byte;

  logic                 flash_active;
  scene_pkg::flash_wr_t flash_wr;
  logic                 flash_wen;

  // Serial line to bytes
  uart_rx u_uart_rx (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte)
  );

  // Bytes to complete commands
  uart_memflash_rtx u_collector (
    .clk          (clk),
    .rst          (rst),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .flash_active (flash_active),
    .flash_wr     (flash_wr),
    .flash_wen    (flash_wen)
  );

  // Commands to scene state
  scene_regs u_scene_regs (
    .clk         (clk),
    .rst         (rst),
    .flash_wen   (flash_wen),
    .flash_wr    (flash_wr),
    .obj_rd_idx  (obj_rd_idx),
    .obj_rd_data (obj_rd_data),
    .camera      (camera),
    .num_objs    (num_objs),
    .max_bounces (max_bounces)
  );

  // Busy while a command is being collected
  assign loader_busy = flash_active;

endmodule

// ==== bench/scene_loader_sva.sv ====
`timescale 1ns/1ps

module scene_loader_sva (
  input logic clk,
  input logic rst,
  input logic flash_active,
  input logic flash_wen
);

  int fail_count = 0;

  // ==============================
  // Write strobe
  // ==============================

  // One cycle per completed command
  property wen_single_cycle;
    @(posedge clk) disable iff (rst)
      flash_wen |=> !flash_wen;
  endproperty

  // Strobe only while a command is open
  property wen_while_active;
    @(posedge clk) disable iff (rst)
      flash_wen |-> flash_active;
  endproperty

  // ==============================
  // Reset
  // ==============================

  property quiet_after_reset;
    @(posedge clk)
      rst |=> (!flash_active && !flash_wen);
  endproperty

  a_wen_single_cycle: assert property (wen_single_cycle)
    else begin
      fail_count++;
      $error("flash_wen stayed high for more than one cycle");
    end

  a_wen_while_active: assert property (wen_while_active)
    else begin
      fail_count++;
      $error("flash_wen high while flash_active is low");
    end

  a_quiet_after_reset: assert property (quiet_after_reset)
    else begin
      fail_count++;
      $error("collector strobes not low after reset");
    end

endmodule

bind uart_memflash_rtx scene_loader_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .flash_active (flash_active),
  .flash_wen    (flash_wen)
);

// ==== bench/scene_loader_tb.sv ====
`timescale 1ns/1ps

module scene_loader_tb;

  typedef logic [191:0] wide_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 rx;
  scene_pkg::obj_idx_t  obj_rd_idx;
  scene_pkg::object_t   obj_rd_data;
  scene_pkg::camera_t   camera;
  scene_pkg::obj_idx_t  num_objs;
  scene_pkg::bounces_t  max_bounces;
  logic                 loader_busy;

  // Command list built before the run starts
  scene_pkg::byte_t       q_cmd[$];
  scene_pkg::flash_data_t q_data[$];
  string                  q_name[$];
  bit                     q_b2b[$];
  int                     total_bytes = 0;

  // Expected scene state
  scene_pkg::camera_t   exp_camera;
  scene_pkg::obj_idx_t  exp_ptr;
  scene_pkg::object_t   exp_objs[scene_pkg::NUM_OBJS];
  bit                   exp_written[scene_pkg::NUM_OBJS];
  scene_pkg::obj_idx_t  exp_num_objs;
  scene_pkg::bounces_t  exp_bounces;

  int  checks_sent = 0;
  int  checks_done = 0;
  int  error_count = 0;
  bit  wd_armed = 1'b0;
  real wd_limit_ns;

  scene_loader uut (
    .clk         (clk),
    .rst         (rst),
    .rx          (rx),
    .obj_rd_idx  (obj_rd_idx),
    .obj_rd_data (obj_rd_data),
    .camera      (camera),
    .num_objs    (num_objs),
    .max_bounces (max_bounces),
    .loader_busy (loader_busy)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ==============================
  // Helpers
  // ==============================

  task automatic check(input string name, input wide_t exp_val, input wide_t act_val);
    if (act_val !== exp_val) begin
      error_count++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp_val, act_val);
      $display("Verification failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Payload length in bytes (zero for codes the loader ignores)
  function automatic int payload_len(input scene_pkg::byte_t cmd);
    if (cmd <= 8'h03) begin
      return 6;
    end else if (cmd == 8'h05) begin
      return 11;
    end else if (cmd <= 8'h07) begin
      return 1;
    end
    return 0;
  endfunction

  function automatic scene_pkg::flash_data_t rand_payload(input int nbytes);
    scene_pkg::flash_data_t d;
    int i;
    d = '0;
    for (i = 0; i < nbytes; i++) begin
      d[8*i +: 8] = 8'($urandom);
    end
    return d;
  endfunction

  function automatic void add_cmd(input string name, input scene_pkg::byte_t cmd,
                                  input scene_pkg::flash_data_t data, input bit b2b);
    q_name.push_back(name);
    q_cmd.push_back(cmd);
    q_data.push_back(data);
    q_b2b.push_back(b2b);
    total_bytes += 1 + payload_len(cmd);
  endfunction

  // ==============================
  // Reference model
  // ==============================

  // First byte pair of the MSB-first payload is x
  function automatic scene_pkg::fp_vec3_t vec_from_payload(input scene_pkg::flash_data_t d);
    scene_pkg::fp_vec3_t v;
    v.x = d[47:32];
    v.y = d[31:16];
    v.z = d[15:0];
    return v;
  endfunction

  function automatic scene_pkg::object_t obj_from_payload(input scene_pkg::flash_data_t d);
    scene_pkg::object_t o;
    o.center.x = d[87:72];
    o.center.y = d[71:56];
    o.center.z = d[55:40];
    o.radius   = d[39:24];
    o.color    = d[23:0];
    return o;
  endfunction

  function automatic void model_apply(input scene_pkg::byte_t cmd,
                                      input scene_pkg::flash_data_t data);
    case (cmd)
      8'h00: exp_camera.pos   = vec_from_payload(data);
      8'h01: exp_camera.dir   = vec_from_payload(data);
      8'h02: exp_camera.right = vec_from_payload(data);
      8'h03: exp_camera.up    = vec_from_payload(data);
      8'h04: exp_ptr = data[3:0];
      8'h05: begin
        exp_objs[exp_ptr]    = obj_from_payload(data);
        exp_written[exp_ptr] = 1'b1;
        // Wraps from 15 back to 0
        exp_ptr = exp_ptr + 4'd1;
      end
      8'h06: exp_num_objs = data[3:0];
      8'h07: exp_bounces  = data[7:0];
      default: begin
      end
    endcase
  endfunction

  // ==============================
  // Serial driver
  // ==============================

  // Starts and ends on a falling edge
  task automatic send_byte(input scene_pkg::byte_t b);
    int i;
    rx = 1'b0;
    repeat (scene_pkg::CLKS_PER_BIT) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (scene_pkg::CLKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;
    repeat (scene_pkg::CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic send_cmd(input scene_pkg::byte_t cmd, input scene_pkg::flash_data_t data);
    int i;
    send_byte(cmd);
    for (i = payload_len(cmd) - 1; i >= 0; i--) begin
      send_byte(data[8*i +: 8]);
    end
  endtask

  function automatic void build_tests();
    int c;
    int r;
    scene_pkg::byte_t cmd;
    for (c = 0; c < 4; c++) begin
      add_cmd($sformatf("camera %0d", c), 8'(c), rand_payload(6), 1'b0);
    end
    // Pointer starts at 13 so the writes wrap past 15
    add_cmd("object index", 8'h04, 128'hfd, 1'b0);
    for (c = 0; c < 6; c++) begin
      add_cmd("object data", 8'h05, rand_payload(11), 1'b0);
    end
    add_cmd("object index", 8'h04, 128'h05, 1'b0);
    add_cmd("object data", 8'h05, rand_payload(11), 1'b0);
    add_cmd("object data", 8'h05, rand_payload(11), 1'b0);
    add_cmd("num objs", 8'h06, rand_payload(1), 1'b0);
    add_cmd("max bounces", 8'h07, rand_payload(1), 1'b0);
    add_cmd("num objs", 8'h06, 128'h0b, 1'b0);
    add_cmd("max bounces", 8'h07, 128'hff, 1'b0);
    add_cmd("unknown cmd", 8'h2a, '0, 1'b0);
    add_cmd("unknown cmd", 8'hff, '0, 1'b0);
    add_cmd("after unknown", 8'h03, rand_payload(6), 1'b0);
    // Mixed stream with no idle gap and about one unknown code in nine
    for (c = 0; c < 40; c++) begin
      r = int'($urandom_range(0, 8));
      if (r == 8) begin
        cmd = 8'($urandom_range(8, 255));
      end else begin
        cmd = 8'(r);
      end
      add_cmd($sformatf("stream %0d", c), cmd, rand_payload(payload_len(cmd)), 1'b1);
    end
  endfunction

  // ==============================
  // Stimulus
  // ==============================

  initial begin : stimulus
    int k;
    rst        = 1'b1;
    rx         = 1'b1;
    obj_rd_idx = '0;
    exp_camera   = '0;
    exp_ptr      = '0;
    exp_num_objs = '0;
    exp_bounces  = '0;
    void'($urandom(32'h61ed));
    build_tests();
    // Ten bit periods per byte plus half again
    wd_limit_ns = real'(total_bytes) * 10.0 * real'(scene_pkg::CLKS_PER_BIT) * 40.0 * 1.5;
    wd_armed = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("reset camera", '0, wide_t'(camera));
    check("reset num objs", '0, wide_t'(num_objs));
    check("reset max bounces", '0, wide_t'(max_bounces));
    check("reset busy", '0, wide_t'(loader_busy));
    for (k = 0; k < q_cmd.size(); k++) begin
      send_cmd(q_cmd[k], q_data[k]);
      model_apply(q_cmd[k], q_data[k]);
      checks_sent++;
      if (!q_b2b[k]) begin
        wait (checks_done == checks_sent);
        @(negedge clk);
      end
    end
    wait (checks_done == checks_sent);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // ==============================
  // Compare
  // ==============================

  // Finishes long before the next command can complete
  initial begin : compare
    string lbl;
    int i;
    forever begin
      wait (checks_sent > checks_done);
      lbl = q_name[checks_done];
      repeat (2 * scene_pkg::CLKS_PER_BIT) @(negedge clk);
      check({lbl, " camera"}, wide_t'(exp_camera), wide_t'(camera));
      check({lbl, " num objs"}, wide_t'(exp_num_objs), wide_t'(num_objs));
      check({lbl, " max bounces"}, wide_t'(exp_bounces), wide_t'(max_bounces));
      check({lbl, " busy"}, '0, wide_t'(loader_busy));
      for (i = 0; i < scene_pkg::NUM_OBJS; i++) begin
        if (exp_written[i]) begin
          obj_rd_idx = 4'(i);
          @(negedge clk);
          check($sformatf("%s object %0d", lbl, i), wide_t'(exp_objs[i]),
                wide_t'(obj_rd_data));
        end
      end
      checks_done++;
    end
  end

  // Bound collector assertions count their failures
  initial begin : assertion_watch
    wait (uut.u_collector.u_sva.fail_count != 0);
    $display("A collector assertion failed");
    $display("Verification failed");
    $fatal(1, "Assertion failure");
  end

  initial begin : watchdog
    wait (wd_armed);
    #(wd_limit_ns);
    $display("Timeout: the run did not finish within %0.0f ns", wd_limit_ns);
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== scene_loader.f ====
verilog/scene_pkg.sv
verilog/uart_rx.sv
verilog/uart_memflash_rtx.sv
verilog/scene_regs.sv
verilog/scene_loader.sv
bench/scene_loader_sva.sv
bench/scene_loader_tb.sv

// ==== Makefile ====
# Verilator build and run for the scene loader

TOP := scene_loader_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f scene_loader.f

obj_dir/V$(TOP): scene_loader.f
	verilator --binary --timing --top-module $(TOP) -f scene_loader.f

sim:
	verilator --binary --timing --top-module $(TOP) -f scene_loader.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" sim.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
